// File: calc_pkg.sv
`default_nettype none

package calc_pkg;

    ////////////////////////////////////////
    // data widths
    ////////////////////////////////////////
    localparam int VALUE_W = 16;
    localparam int DIGIT_W = 4;
    localparam int PHASE_W = 2;
    localparam int OP_W    = 2;

    // confirmation sequence A -> B -> result -> A
    localparam logic [PHASE_W-1:0] PHASE_A      = 2'd0;
    localparam logic [PHASE_W-1:0] PHASE_B      = 2'd1;
    localparam logic [PHASE_W-1:0] PHASE_RESULT = 2'd2;

    // op code 3 falls back to add
    localparam logic [OP_W-1:0] OP_ADD = 2'd0;
    localparam logic [OP_W-1:0] OP_SUB = 2'd1;
    localparam logic [OP_W-1:0] OP_MUL = 2'd2;

    // cursor places, left press counts upward
    localparam logic [1:0] PLACE_ONES     = 2'd0;
    localparam logic [1:0] PLACE_TENS     = 2'd1;
    localparam logic [1:0] PLACE_HUNDREDS = 2'd2;
    localparam logic [1:0] PLACE_SIGN     = 2'd3;

    localparam logic [VALUE_W-1:0] DISPLAY_LIMIT     = 16'd999;
    // 100 MHz board clock, tick every 0.5 ms
    localparam logic [31:0]        TICK_DIVIDE_BOARD = 32'd50_000;

endpackage

`default_nettype wire

// File: tick_divider.sv
`default_nettype none
`timescale 1ns/100ps

module tick_divider #(
    parameter logic [31:0] tick_divide = calc_pkg::TICK_DIVIDE_BOARD
) (
    input  logic clk,
    input  logic reset,
    output logic sample_tick
);

    localparam int CNT_W = (tick_divide > 32'd1) ? $clog2(tick_divide) : 1;

    logic [CNT_W-1:0] count;
    logic             wrap;

    assign wrap = (count == CNT_W'(tick_divide - 32'd1));

    // free running counter, tick registered at the wrap
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count       <= '0;
            sample_tick <= 1'b0;
        end else begin
            count       <= wrap ? '0 : count + 1'b1;
            sample_tick <= wrap;
        end
    end

endmodule

`default_nettype wire

// File: button_debouncer.sv
`default_nettype none
`timescale 1ns/100ps

module button_debouncer (
    input  logic clk,
    input  logic reset,
    input  logic sample_tick,
    input  logic button,
    output logic press
);

    // stage 0 samples the raw level, stages 1 and 2 form the edge detector
    logic [2:0] sample_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sample_q <= 3'b000;
        end else if (sample_tick) begin
            sample_q <= {sample_q[1:0], button};
        end
    end

    // one clk wide pulse, only in the tick cycle that sees the rising edge
    assign press = sample_tick & sample_q[1] & ~sample_q[2];

endmodule

`default_nettype wire

// File: digit_entry.sv
`default_nettype none
`timescale 1ns/100ps

module digit_entry (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                press_c,
    input  logic                                press_u,
    input  logic                                press_l,
    input  logic                                press_r,
    input  logic                                press_d,
    output logic signed [calc_pkg::VALUE_W-1:0] entry_value,
    output logic        [calc_pkg::DIGIT_W-1:0] ones,
    output logic        [calc_pkg::DIGIT_W-1:0] tens,
    output logic        [calc_pkg::DIGIT_W-1:0] hundreds,
    output logic                                entry_negative,
    output logic        [1:0]                   cursor,
    output logic        [calc_pkg::PHASE_W-1:0] phase,
    output logic                                confirm
);

    import calc_pkg::*;

    localparam logic [DIGIT_W-1:0] DIGIT_MAX = 4'd9;

    logic [DIGIT_W-1:0] ones_n;
    logic [DIGIT_W-1:0] tens_n;
    logic [DIGIT_W-1:0] hundreds_n;
    logic               negative_n;
    logic [1:0]         cursor_n;
    logic [PHASE_W-1:0] phase_n;
    logic [VALUE_W-1:0] magnitude_n;

    assign confirm = press_c;

    ////////////////////////////////////////
    // next state, one press per cycle
    ////////////////////////////////////////
    always_comb begin
        ones_n     = ones;
        tens_n     = tens;
        hundreds_n = hundreds;
        negative_n = entry_negative;
        cursor_n   = cursor;
        phase_n    = phase;

        if (press_c) begin
            ones_n     = '0;
            tens_n     = '0;
            hundreds_n = '0;
            negative_n = 1'b0;
            cursor_n   = PLACE_ONES;
            case (phase)
                PHASE_A: phase_n = PHASE_B;
                PHASE_B: phase_n = PHASE_RESULT;
                default: phase_n = PHASE_A;
            endcase
        end else if (press_l) begin
            // toward the sign place, wraps back to ones
            cursor_n = cursor + 2'd1;
        end else if (press_r) begin
            cursor_n = cursor - 2'd1;
        end else if (press_u) begin
            case (cursor)
                PLACE_ONES:     if (ones < DIGIT_MAX) ones_n = ones + 1'b1;
                PLACE_TENS:     if (tens < DIGIT_MAX) tens_n = tens + 1'b1;
                PLACE_HUNDREDS: if (hundreds < DIGIT_MAX) hundreds_n = hundreds + 1'b1;
                PLACE_SIGN:     negative_n = ~entry_negative;
            endcase
        end else if (press_d) begin
            case (cursor)
                PLACE_ONES:     if (ones != '0) ones_n = ones - 1'b1;
                PLACE_TENS:     if (tens != '0) tens_n = tens - 1'b1;
                PLACE_HUNDREDS: if (hundreds != '0) hundreds_n = hundreds - 1'b1;
                PLACE_SIGN:     negative_n = ~entry_negative;
            endcase
        end
    end

    // value is always rebuilt from the digits and the sign
    assign magnitude_n = VALUE_W'(hundreds_n) * 16'd100
                       + VALUE_W'(tens_n) * 16'd10
                       + VALUE_W'(ones_n);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ones           <= '0;
            tens           <= '0;
            hundreds       <= '0;
            entry_negative <= 1'b0;
            cursor         <= PLACE_ONES;
            phase          <= PHASE_A;
            entry_value    <= '0;
        end else begin
            ones           <= ones_n;
            tens           <= tens_n;
            hundreds       <= hundreds_n;
            entry_negative <= negative_n;
            cursor         <= cursor_n;
            phase          <= phase_n;
            entry_value    <= negative_n ? -magnitude_n : magnitude_n;
        end
    end

endmodule

`default_nettype wire

// File: arithmetic_unit.sv
`default_nettype none
`timescale 1ns/100ps

module arithmetic_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                confirm,
    input  logic        [calc_pkg::PHASE_W-1:0] phase,
    input  logic signed [calc_pkg::VALUE_W-1:0] entry_value,
    input  logic        [calc_pkg::OP_W-1:0]    op_select,
    output logic signed [calc_pkg::VALUE_W-1:0] result,
    output logic                                overflow
);

    import calc_pkg::*;

    // wide enough for 999 * 999
    localparam int RAW_W = 2 * VALUE_W;

    logic signed [VALUE_W-1:0] operand_a;
    logic signed [VALUE_W-1:0] operand_b;
    logic signed [RAW_W-1:0]   a_ext;
    logic signed [RAW_W-1:0]   b_ext;
    logic signed [RAW_W-1:0]   raw;
    logic signed [RAW_W-1:0]   limit_hi;
    logic signed [RAW_W-1:0]   limit_lo;

    // operands latch on the same edge as the phase change
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            operand_a <= '0;
            operand_b <= '0;
        end else if (confirm) begin
            if (phase == PHASE_A) operand_a <= entry_value;
            if (phase == PHASE_B) operand_b <= entry_value;
        end
    end

    assign a_ext    = operand_a;
    assign b_ext    = operand_b;
    assign limit_hi = RAW_W'(DISPLAY_LIMIT);
    assign limit_lo = -limit_hi;

    always_comb begin
        case (op_select)
            OP_ADD:  raw = a_ext + b_ext;
            OP_SUB:  raw = a_ext - b_ext;
            OP_MUL:  raw = a_ext * b_ext;
            default: raw = a_ext + b_ext;
        endcase
    end

    ////////////////////////////////////////
    // saturate to the display range
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result   <= '0;
            overflow <= 1'b0;
        end else if (raw > limit_hi) begin
            result   <= VALUE_W'(limit_hi);
            overflow <= 1'b1;
        end else if (raw < limit_lo) begin
            result   <= VALUE_W'(limit_lo);
            overflow <= 1'b1;
        end else begin
            result   <= VALUE_W'(raw);
            overflow <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: result_to_digits.sv
`default_nettype none
`timescale 1ns/100ps

module result_to_digits (
    input  logic signed [calc_pkg::VALUE_W-1:0] result,
    output logic                                result_negative,
    output logic        [calc_pkg::DIGIT_W-1:0] ones,
    output logic        [calc_pkg::DIGIT_W-1:0] tens,
    output logic        [calc_pkg::DIGIT_W-1:0] hundreds
);

    import calc_pkg::*;

    logic [VALUE_W-1:0] magnitude;

    assign result_negative = result[VALUE_W-1];
    assign magnitude       = result_negative ? -result : result;

    // input is already saturated, so nine steps per place are enough
    always_comb begin
        logic [VALUE_W-1:0] rem;
        logic [DIGIT_W-1:0] h;
        logic [DIGIT_W-1:0] t;

        rem = magnitude;
        h   = '0;
        t   = '0;
        for (int i = 0; i < 9; i++) begin
            if (rem >= 16'd100) begin
                rem = rem - 16'd100;
                h   = h + 1'b1;
            end
        end
        for (int i = 0; i < 9; i++) begin
            if (rem >= 16'd10) begin
                rem = rem - 16'd10;
                t   = t + 1'b1;
            end
        end

        hundreds = h;
        tens     = t;
        // what remains is below ten
        ones     = rem[DIGIT_W-1:0];
    end

endmodule

`default_nettype wire

// File: calculator_top.sv
`default_nettype none
`timescale 1ns/100ps

module calculator_top #(
    parameter logic [31:0] tick_divide = calc_pkg::TICK_DIVIDE_BOARD
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                btn_c,
    input  logic                                btn_u,
    input  logic                                btn_l,
    input  logic                                btn_r,
    input  logic                                btn_d,
    input  logic        [calc_pkg::OP_W-1:0]    op_select,
    output logic        [calc_pkg::DIGIT_W-1:0] ones,
    output logic        [calc_pkg::DIGIT_W-1:0] tens,
    output logic        [calc_pkg::DIGIT_W-1:0] hundreds,
    output logic                                negative,
    output logic        [1:0]                   cursor,
    output logic        [calc_pkg::PHASE_W-1:0] phase,
    output logic signed [calc_pkg::VALUE_W-1:0] entry_value,
    output logic signed [calc_pkg::VALUE_W-1:0] result,
    output logic                                overflow
);

    import calc_pkg::*;

    logic               sample_tick;
    logic               press_c;
    logic               press_u;
    logic               press_l;
    logic               press_r;
    logic               press_d;
    logic               confirm;
    logic [DIGIT_W-1:0] entry_ones;
    logic [DIGIT_W-1:0] entry_tens;
    logic [DIGIT_W-1:0] entry_hundreds;
    logic               entry_negative;
    logic [DIGIT_W-1:0] result_ones;
    logic [DIGIT_W-1:0] result_tens;
    logic [DIGIT_W-1:0] result_hundreds;
    logic               result_negative;

    ////////////////////////////////////////
    // button front end
    ////////////////////////////////////////
    tick_divider #(
        .tick_divide(tick_divide)
    ) u_tick_divider (
        .clk        (clk),
        .reset      (reset),
        .sample_tick(sample_tick)
    );

    button_debouncer u_deb_c (.clk(clk), .reset(reset), .sample_tick(sample_tick),
                              .button(btn_c), .press(press_c));
    button_debouncer u_deb_u (.clk(clk), .reset(reset), .sample_tick(sample_tick),
                              .button(btn_u), .press(press_u));
    button_debouncer u_deb_l (.clk(clk), .reset(reset), .sample_tick(sample_tick),
                              .button(btn_l), .press(press_l));
    button_debouncer u_deb_r (.clk(clk), .reset(reset), .sample_tick(sample_tick),
                              .button(btn_r), .press(press_r));
    button_debouncer u_deb_d (.clk(clk), .reset(reset), .sample_tick(sample_tick),
                              .button(btn_d), .press(press_d));

    ////////////////////////////////////////
    // entry and arithmetic
    ////////////////////////////////////////
    digit_entry u_digit_entry (
        .clk           (clk),
        .reset         (reset),
        .press_c       (press_c),
        .press_u       (press_u),
        .press_l       (press_l),
        .press_r       (press_r),
        .press_d       (press_d),
        .entry_value   (entry_value),
        .ones          (entry_ones),
        .tens          (entry_tens),
        .hundreds      (entry_hundreds),
        .entry_negative(entry_negative),
        .cursor        (cursor),
        .phase         (phase),
        .confirm       (confirm)
    );

    arithmetic_unit u_arithmetic_unit (
        .clk        (clk),
        .reset      (reset),
        .confirm    (confirm),
        .phase      (phase),
        .entry_value(entry_value),
        .op_select  (op_select),
        .result     (result),
        .overflow   (overflow)
    );

    result_to_digits u_result_to_digits (
        .result         (result),
        .result_negative(result_negative),
        .ones           (result_ones),
        .tens           (result_tens),
        .hundreds       (result_hundreds)
    );

    // result digits only while in the result phase
    always_comb begin
        if (phase == PHASE_RESULT) begin
            ones     = result_ones;
            tens     = result_tens;
            hundreds = result_hundreds;
            negative = result_negative;
        end else begin
            ones     = entry_ones;
            tens     = entry_tens;
            hundreds = entry_hundreds;
            negative = entry_negative;
        end
    end

endmodule

`default_nettype wire

// File: calculator_checker.sv
`default_nettype none
`timescale 1ns/100ps

module calculator_checker (
    input logic                                clk,
    input logic                                reset,
    input logic        [calc_pkg::PHASE_W-1:0] phase,
    input logic        [calc_pkg::DIGIT_W-1:0] ones,
    input logic        [calc_pkg::DIGIT_W-1:0] tens,
    input logic        [calc_pkg::DIGIT_W-1:0] hundreds,
    input logic signed [calc_pkg::VALUE_W-1:0] result,
    input logic                                overflow,
    input logic                                confirm
);

    import calc_pkg::*;

    // phase code 3 is unused
    phase_valid: assert property (@(posedge clk) disable iff (reset) phase != 2'd3)
        else $error("phase holds the unused code 3");

    digits_decimal: assert property (@(posedge clk) disable iff (reset)
        ones <= 4'd9 && tens <= 4'd9 && hundreds <= 4'd9)
        else $error("a displayed digit is above 9");

    // saturated result sits exactly on a limit
    overflow_at_limit: assert property (@(posedge clk) disable iff (reset)
        overflow |-> (result == DISPLAY_LIMIT || result == -DISPLAY_LIMIT))
        else $error("overflow set while result is off the display limit");

    confirm_single: assert property (@(posedge clk) disable iff (reset) confirm |=> !confirm)
        else $error("confirm high on two consecutive cycles");

endmodule

bind calculator_top calculator_checker checker_i (
    .clk(clk), .reset(reset), .phase(phase),
    .ones(ones), .tens(tens), .hundreds(hundreds),
    .result(result), .overflow(overflow), .confirm(confirm)
);

`default_nettype wire

// File: tb_calculator.sv
`default_nettype none
`timescale 1ns/100ps

module tb_calculator;

    import calc_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int HOLD_CYCLES     = 16;
    localparam int CYCLES_PER_LINE = 40;

    logic                      clk;
    logic                      reset;
    logic                      btn_c;
    logic                      btn_u;
    logic                      btn_l;
    logic                      btn_r;
    logic                      btn_d;
    logic [OP_W-1:0]           op_select;
    logic [DIGIT_W-1:0]        ones;
    logic [DIGIT_W-1:0]        tens;
    logic [DIGIT_W-1:0]        hundreds;
    logic                      negative;
    logic [1:0]                cursor;
    logic [PHASE_W-1:0]        phase;
    logic signed [VALUE_W-1:0] entry_value;
    logic signed [VALUE_W-1:0] result;
    logic                      overflow;

    // one entry per stimulus line
    logic [7:0] btn_q[$];
    int         op_q[$];
    int         phase_q[$];
    int         cursor_q[$];
    int         value_q[$];
    int         ones_q[$];
    int         tens_q[$];
    int         hundreds_q[$];
    int         negative_q[$];
    int         result_q[$];
    int         overflow_q[$];
    bit         loaded;
    int         seed;
    int         gap;

    calculator_top #(
        .tick_divide(32'd4)
    ) dut_i (
        .clk(clk), .reset(reset),
        .btn_c(btn_c), .btn_u(btn_u), .btn_l(btn_l), .btn_r(btn_r), .btn_d(btn_d),
        .op_select(op_select),
        .ones(ones), .tens(tens), .hundreds(hundreds), .negative(negative),
        .cursor(cursor), .phase(phase), .entry_value(entry_value),
        .result(result), .overflow(overflow)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // failure reporting and compare tasks
    ////////////////////////////////////////
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input string actual, input string expected);
        stop_with_failure($sformatf("** Error at %0d ns: %s is %s, expected %s",
                                    $time, name, actual, expected));
    endtask

    task automatic check_digit(input string name, input logic [DIGIT_W-1:0] actual,
                               input logic [DIGIT_W-1:0] expected);
        if (actual !== expected)
            report_mismatch(name, $sformatf("%0d", actual), $sformatf("%0d", expected));
    endtask

    task automatic check_value(input string name, input logic signed [VALUE_W-1:0] actual,
                               input logic signed [VALUE_W-1:0] expected);
        if (actual !== expected)
            report_mismatch(name, $sformatf("%0d", actual), $sformatf("%0d", expected));
    endtask

    task automatic check_phase(input string name, input logic [PHASE_W-1:0] actual,
                               input logic [PHASE_W-1:0] expected);
        if (actual !== expected)
            report_mismatch(name, $sformatf("%0d", actual), $sformatf("%0d", expected));
    endtask

    task automatic check_cursor(input string name, input logic [1:0] actual,
                                input logic [1:0] expected);
        if (actual !== expected)
            report_mismatch(name, $sformatf("%0d", actual), $sformatf("%0d", expected));
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            report_mismatch(name, $sformatf("%b", actual), $sformatf("%b", expected));
    endtask

    ////////////////////////////////////////
    // stimulus file and button presses
    ////////////////////////////////////////
    task automatic load_stimulus();
        int         fd;
        int         n;
        string      line_s;
        logic [7:0] b;
        int         op, ph, cu, ev, o, t, h, ng, res, ov;

        fd = $fopen("calculator_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the stimulus file calculator_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line_s = "";
                void'($fgets(line_s, fd));
                // skip blank lines and the column notes
                if (line_s.len() > 1 && line_s[0] != "#") begin
                    n = $sscanf(line_s, "%c %d %d %d %d %d %d %d %d %d %d",
                                b, op, ph, cu, ev, o, t, h, ng, res, ov);
                    if (n != 11)
                        stop_with_failure({"malformed stimulus line: ", line_s});
                    btn_q.push_back(b);
                    op_q.push_back(op);
                    phase_q.push_back(ph);
                    cursor_q.push_back(cu);
                    value_q.push_back(ev);
                    ones_q.push_back(o);
                    tens_q.push_back(t);
                    hundreds_q.push_back(h);
                    negative_q.push_back(ng);
                    result_q.push_back(res);
                    overflow_q.push_back(ov);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic set_button(input logic [7:0] which, input logic level);
        case (which)
            "c": btn_c = level;
            "u": btn_u = level;
            "l": btn_l = level;
            "r": btn_r = level;
            "d": btn_d = level;
            "n": ;
            default: stop_with_failure($sformatf("unknown button letter '%c'", which));
        endcase
    endtask

    // long enough for three ticks high and three ticks low at tick_divide 4
    task automatic press_button(input logic [7:0] which);
        set_button(which, 1'b1);
        repeat (HOLD_CYCLES) @(negedge clk);
        set_button(which, 1'b0);
        repeat (HOLD_CYCLES) @(negedge clk);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        btn_c     = 1'b0;
        btn_u     = 1'b0;
        btn_l     = 1'b0;
        btn_r     = 1'b0;
        btn_d     = 1'b0;
        op_select = OP_ADD;
        loaded    = 1'b0;
        seed      = 32'h76e8d06c;

        load_stimulus();
        loaded = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < btn_q.size(); i++) begin
            gap = $unsigned($random(seed)) % 8;
            repeat (gap) @(negedge clk);
            op_select = OP_W'(op_q[i]);
            press_button(btn_q[i]);
            check_phase("phase", phase, PHASE_W'(phase_q[i]));
            check_cursor("cursor", cursor, 2'(cursor_q[i]));
            check_value("entry_value", entry_value, VALUE_W'(value_q[i]));
            check_digit("ones", ones, DIGIT_W'(ones_q[i]));
            check_digit("tens", tens, DIGIT_W'(tens_q[i]));
            check_digit("hundreds", hundreds, DIGIT_W'(hundreds_q[i]));
            check_flag("negative", negative, 1'(negative_q[i]));
            check_value("result", result, VALUE_W'(result_q[i]));
            check_flag("overflow", overflow, 1'(overflow_q[i]));
        end

        $display("Test OK");
        $finish;
    end

    // watchdog sized from the number of stimulus lines
    initial begin
        int watchdog_ns;

        wait (loaded);
        watchdog_ns = (btn_q.size() * CYCLES_PER_LINE + 100) * CLK_PERIOD;
        #(watchdog_ns);
        stop_with_failure("timeout, the stimulus did not finish in time");
    end

endmodule

`default_nettype wire

// File: calculator_stimulus.txt
# button op | expected: phase cursor entry_value ones tens hundreds negative result overflow
# button n presses nothing and only applies the op select
n 0 0 0 0 0 0 0 0 0 0
d 0 0 0 0 0 0 0 0 0 0
u 0 0 0 1 1 0 0 0 0 0
u 0 0 0 2 2 0 0 0 0 0
r 0 0 3 2 2 0 0 0 0 0
u 0 0 3 -2 2 0 0 1 0 0
r 0 0 2 -2 2 0 0 1 0 0
u 0 0 2 -102 2 0 1 1 0 0
r 0 0 1 -102 2 0 1 1 0 0
u 0 0 1 -112 2 1 1 1 0 0
l 0 0 2 -112 2 1 1 1 0 0
l 0 0 3 -112 2 1 1 1 0 0
d 0 0 3 112 2 1 1 0 0 0
u 0 0 3 -112 2 1 1 1 0 0
l 0 0 0 -112 2 1 1 1 0 0
c 0 1 0 0 0 0 0 0 -112 0
u 0 1 0 1 1 0 0 0 -112 0
u 0 1 0 2 2 0 0 0 -112 0
u 0 1 0 3 3 0 0 0 -112 0
u 0 1 0 4 4 0 0 0 -112 0
u 0 1 0 5 5 0 0 0 -112 0
u 0 1 0 6 6 0 0 0 -112 0
u 0 1 0 7 7 0 0 0 -112 0
u 0 1 0 8 8 0 0 0 -112 0
u 0 1 0 9 9 0 0 0 -112 0
u 0 1 0 9 9 0 0 0 -112 0
c 0 2 0 0 3 0 1 1 -103 0
n 1 2 0 0 1 2 1 1 -121 0
n 2 2 0 0 9 9 9 1 -999 1
n 3 2 0 0 3 0 1 1 -103 0
c 0 0 0 0 0 0 0 0 -103 0

// File: compile.f
calc_pkg.sv
tick_divider.sv
button_debouncer.sv
digit_entry.sv
arithmetic_unit.sv
result_to_digits.sv
calculator_top.sv
calculator_checker.sv
tb_calculator.sv

// File: run_sim.sh
#!/bin/sh
set -e

verilator --binary --assert -Wno-fatal --top-module tb_calculator -f compile.f -o tb_calculator

# the run result is taken from the log, not from the exit status
./obj_dir/tb_calculator > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    exit 1
fi
